// ==== hw/pc_params.svh ====
/*
 * Shared constants for the fetch and control-flow block:
 * widths, PC step, PC operation codes, config register map.
 */
`ifndef PC_PARAMS_SVH
`define PC_PARAMS_SVH

`define PC_WIDTH          32
`define INSTR_WIDTH       32
`define PC_OP_WIDTH       2
`define CFG_ADDR_WIDTH    2
`define CFG_DATA_WIDTH    32
`define FAULT_COUNT_WIDTH 16

`define PC_STEP 4 // Sequential increment in bytes

// PC operations
`define PC_OP_NEXT 2'd0 // pc + 4
`define PC_OP_LOAD 2'd1 // in[31:2]
`define PC_OP_REL  2'd2 // pc + offset
`define PC_OP_COND 2'd3 // in[0] ? pc + offset : pc + 4

// Config register addresses
`define CFG_REG_CTRL   2'd0
`define CFG_REG_TRAP   2'd1
`define CFG_REG_FAULTS 2'd2
`define CFG_REG_STATUS 2'd3

`endif

// ==== hw/pc_pkg.sv ====
/*
 * Fetch package
 * Vector types shared by the fetch RTL and its testbench
 */
`include "pc_params.svh"

package pc_pkg;

    // PC or byte address
    typedef logic [`PC_WIDTH-1:0] addr_t;

    // Raw instruction word with kind in 31:30 and operand in 29:0
    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // PC update operation
    typedef logic [`PC_OP_WIDTH-1:0] pc_op_t;

    // Host port address and data
    typedef logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`CFG_DATA_WIDTH-1:0] cfg_data_t;

    // Saturating fault counter
    typedef logic [`FAULT_COUNT_WIDTH-1:0] fault_count_t;

endpackage

// ==== hw/program_counter.sv ====
/*
 * Program counter
 * Holds the PC and applies next, load, relative or conditional
 * relative updates when step is high. A misaligned target raises fault.
 */
`timescale 1ns/10ps
`include "pc_params.svh"

module program_counter (
    input  logic          clk,
    input  logic          reset,
    input  logic          step,    // One-cycle update enable
    input  pc_pkg::pc_op_t op,
    input  pc_pkg::addr_t  offset, // Byte offset for REL and COND
    input  pc_pkg::addr_t  in,     // Load target, or condition in bit 0
    output pc_pkg::addr_t  pc,
    output pc_pkg::addr_t  next_pc,
    output logic          fault
);

    pc_pkg::addr_t pc_offset_sum;
    pc_pkg::addr_t in_target;
    logic          offset_bad;
    logic          in_bad;
    logic          cond_taken;

    assign next_pc       = pc + `PC_STEP;
    assign pc_offset_sum = pc + {offset[`PC_WIDTH-1:2], 2'b00}; // Low bits dropped
    assign in_target     = {in[`PC_WIDTH-1:2], 2'b00};
    assign offset_bad    = offset[1] | offset[0];
    assign in_bad        = in[1];
    assign cond_taken    = in[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            fault <= 1'b0;
        end else if (step) begin
            case (op)
                `PC_OP_NEXT: begin
                    pc    <= next_pc;
                    fault <= 1'b0;
                end
                `PC_OP_LOAD: begin
                    pc    <= in_target;
                    fault <= in_bad;
                end
                `PC_OP_REL: begin
                    pc    <= pc_offset_sum; // Updates even when offset is bad
                    fault <= offset_bad;
                end
                default: begin
                    if (cond_taken) begin
                        pc    <= pc_offset_sum;
                        fault <= offset_bad;
                    end else begin
                        pc    <= next_pc;
                        fault <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/flow_decoder.sv ====
/*
 * Flow decoder
 * Maps an instruction word and its sampled condition to a PC
 * operation, offset and input word. trap_sel overrides with a
 * load of the trap vector.
 */
`timescale 1ns/10ps
`include "pc_params.svh"

module flow_decoder (
    input  pc_pkg::instr_t instr,
    input  logic           cond,        // Condition sampled at fetch ack
    input  logic           trap_sel,    // Redirect to trap vector
    input  pc_pkg::addr_t  trap_vector,
    output pc_pkg::pc_op_t op,
    output pc_pkg::addr_t  offset,
    output pc_pkg::addr_t  in
);

    logic [1:0]    kind;
    logic [29:0]   operand;
    pc_pkg::addr_t operand_sext;
    pc_pkg::addr_t operand_zext;

    assign kind         = instr[31:30];
    assign operand      = instr[29:0];
    assign operand_sext = {{2{operand[29]}}, operand}; // Signed byte offset
    assign operand_zext = {2'b00, operand};

    always_comb begin
        op     = `PC_OP_NEXT;
        offset = operand_sext;
        in     = '0;
        if (trap_sel) begin
            op = `PC_OP_LOAD;
            in = trap_vector;
        end else begin
            case (kind)
                2'd0: begin
                    op = `PC_OP_NEXT; // Sequential
                end
                2'd1: begin
                    op = `PC_OP_LOAD; // Jump to an absolute target
                    in = operand_zext;
                end
                2'd2: begin
                    op = `PC_OP_REL;
                end
                default: begin
                    op = `PC_OP_COND;
                    in = {{(`PC_WIDTH-1){1'b0}}, cond}; // Taken flag in bit 0
                end
            endcase
        end
    end

endmodule

// ==== hw/fetch_sequencer.sv ====
/*
 * Fetch sequencer
 * Fetches one instruction at a time over the req/ack memory port,
 * steps the PC, then checks for a fault and either traps, halts
 * or moves on to the next fetch.
 */
`timescale 1ns/10ps

module fetch_sequencer (
    input  logic           clk,
    input  logic           reset,
    input  logic           run,
    input  logic           trap_enable,
    output logic           imem_req,
    output pc_pkg::addr_t  imem_addr,
    input  logic           imem_ack,
    input  pc_pkg::instr_t imem_rdata,
    input  logic           cond,
    input  pc_pkg::addr_t  pc,
    input  logic           fault,
    output logic           step,
    output logic           trap_sel,
    output pc_pkg::instr_t instr,       // Captured at ack
    output logic           cond_q,      // Captured at ack
    output logic           fault_event,
    output logic           fault_halt,
    output logic           halted,
    output logic           retire,
    output pc_pkg::addr_t  retire_pc
);

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        DROP,
        STEP,
        CHECK,
        TRAP
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;
    logic       take_trap;

    assign take_trap = fault & trap_enable;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:  if (run && !imem_ack) state_next = REQ; // Wait out any old ack
            REQ:   if (imem_ack) state_next = DROP;
            DROP:  if (!imem_ack) state_next = STEP;
            STEP:  state_next = CHECK;
            CHECK: begin
                if (take_trap) begin
                    state_next = TRAP;
                end else if (fault || !run) begin
                    state_next = IDLE;
                end else begin
                    state_next = REQ;
                end
            end
            TRAP:  state_next = run ? REQ : IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Instruction, condition and its PC
    always_ff @(posedge clk) begin
        if (state == REQ && imem_ack) begin
            instr  <= imem_rdata;
            cond_q <= cond;
        end
        if (state == STEP) begin
            retire_pc <= pc; // PC before the update
        end
    end

    assign imem_req    = (state == REQ);
    assign imem_addr   = pc; // Stable until the step edge
    assign step        = (state == STEP) || (state == TRAP);
    assign trap_sel    = (state == TRAP);
    assign fault_event = (state == CHECK) && fault;
    assign fault_halt  = (state == CHECK) && fault && !trap_enable;
    assign retire      = ((state == CHECK) && !take_trap) || (state == TRAP);
    assign halted      = (state == IDLE);

endmodule

// ==== hw/fetch_config.sv ====
/*
 * Fetch configuration block
 * Host registers for run, trap enable, trap vector, fault count
 * and a read-only status word, over a four-phase req/ack port.
 */
`timescale 1ns/10ps
`include "pc_params.svh"

module fetch_config (
    input  logic              clk,
    input  logic              reset,
    input  logic              cfg_req,
    input  logic              cfg_we,
    input  pc_pkg::cfg_addr_t cfg_addr,
    input  pc_pkg::cfg_data_t cfg_wdata,
    output logic              cfg_ack,
    output pc_pkg::cfg_data_t cfg_rdata,
    input  logic              fault_event, // One pulse per fault
    input  logic              fault_halt,  // Sequencer halted on a fault
    input  logic              halted,
    input  pc_pkg::addr_t     pc,
    output logic              run,
    output logic              trap_enable,
    output pc_pkg::addr_t     trap_vector
);

    pc_pkg::fault_count_t fault_count;
    pc_pkg::cfg_data_t    read_word;
    logic                 access;
    logic                 wr;
    logic                 count_full;

    assign access     = cfg_req & ~cfg_ack; // First cycle of a request
    assign wr         = access & cfg_we;
    assign count_full = &fault_count;

    always_comb begin
        case (cfg_addr)
            `CFG_REG_CTRL:   read_word = {30'd0, trap_enable, run};
            `CFG_REG_TRAP:   read_word = trap_vector;
            `CFG_REG_FAULTS: read_word = pc_pkg::cfg_data_t'(fault_count);
            default:         read_word = {pc[`PC_WIDTH-1:2], 1'b0, halted};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_ack     <= 1'b0;
            run         <= 1'b0;
            trap_enable <= 1'b0;
            trap_vector <= '0;
            fault_count <= '0;
        end else begin
            cfg_ack <= cfg_req; // Follows req by one cycle on both edges

            if (wr && cfg_addr == `CFG_REG_CTRL) begin
                run         <= cfg_wdata[0];
                trap_enable <= cfg_wdata[1];
            end
            if (fault_halt) begin
                run <= 1'b0; // Halt wins over a host write
            end

            if (wr && cfg_addr == `CFG_REG_TRAP) begin
                trap_vector <= {cfg_wdata[`PC_WIDTH-1:2], 2'b00};
            end

            if (wr && cfg_addr == `CFG_REG_FAULTS) begin
                fault_count <= '0; // Any write clears
            end else if (fault_event && !count_full) begin
                fault_count <= fault_count + 1'b1;
            end
        end
    end

    // Read data held for the whole ack phase
    always_ff @(posedge clk) begin
        if (access) begin
            cfg_rdata <= read_word;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
/*
 * Fetch top level
 * Sequencer, decoder, program counter and config block wired to
 * the instruction memory port and the host port.
 */
`timescale 1ns/10ps

module fetch_top (
    input  logic              clk,
    input  logic              reset,
    output logic              imem_req,
    output pc_pkg::addr_t     imem_addr,
    input  logic              imem_ack,
    input  pc_pkg::instr_t    imem_rdata,
    input  logic              cond,
    input  logic              cfg_req,
    input  logic              cfg_we,
    input  pc_pkg::cfg_addr_t cfg_addr,
    input  pc_pkg::cfg_data_t cfg_wdata,
    output logic              cfg_ack,
    output pc_pkg::cfg_data_t cfg_rdata,
    output logic              halted,
    output logic              retire,
    output pc_pkg::addr_t     retire_pc
);

    logic           run;
    logic           trap_enable;
    pc_pkg::addr_t  trap_vector;
    logic           step;
    logic           trap_sel;
    pc_pkg::instr_t instr;
    logic           cond_q;
    pc_pkg::pc_op_t op;
    pc_pkg::addr_t  offset;
    pc_pkg::addr_t  in_word;
    pc_pkg::addr_t  pc;
    logic           fault;
    logic           fault_event;
    logic           fault_halt;

    program_counter u_pc (
        .clk(clk), .reset(reset), .step(step), .op(op), .offset(offset),
        .in(in_word), .pc(pc), .next_pc(), .fault(fault)
    );

    flow_decoder u_dec (
        .instr(instr), .cond(cond_q), .trap_sel(trap_sel), .trap_vector(trap_vector),
        .op(op), .offset(offset), .in(in_word)
    );

    fetch_sequencer u_seq (
        .clk(clk), .reset(reset), .run(run), .trap_enable(trap_enable),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
        .imem_rdata(imem_rdata), .cond(cond), .pc(pc), .fault(fault),
        .step(step), .trap_sel(trap_sel), .instr(instr), .cond_q(cond_q),
        .fault_event(fault_event), .fault_halt(fault_halt), .halted(halted),
        .retire(retire), .retire_pc(retire_pc)
    );

    fetch_config u_cfg (
        .clk(clk), .reset(reset), .cfg_req(cfg_req), .cfg_we(cfg_we),
        .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_ack(cfg_ack),
        .cfg_rdata(cfg_rdata), .fault_event(fault_event), .fault_halt(fault_halt),
        .halted(halted), .pc(pc), .run(run), .trap_enable(trap_enable),
        .trap_vector(trap_vector)
    );

endmodule

// ==== dv/imem_model.sv ====
/*
 * Instruction memory responder
 * Answers each fetch request after 0 to 3 cycles with the word from
 * a loadable program array and a random branch condition.
 */
`timescale 1ns/10ps

module imem_model #(
    parameter int words = 64
) (
    input  logic           clk,
    input  logic           imem_req,
    input  pc_pkg::addr_t  imem_addr,
    output logic           imem_ack,
    output pc_pkg::instr_t imem_rdata,
    output logic           cond
);

    localparam int index_bits = $clog2(words);

    pc_pkg::instr_t mem [0:words-1]; // Loaded by the testbench
    int             delay;
    int             i;

    initial begin
        for (i = 0; i < words; i++) begin
            mem[i] = {2'b00, 30'(i)}; // Sequential words until a program is loaded
        end
        imem_ack   = 1'b0;
        imem_rdata = '0;
        cond       = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (imem_req && !imem_ack) begin
                delay = int'($urandom % 4);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                imem_rdata = mem[imem_addr[index_bits+1:2]];
                cond       = 1'($urandom % 2); // Held until the next response
                imem_ack   = 1'b1;
                while (imem_req) begin
                    @(posedge clk);
                    #1;
                end
                imem_ack = 1'b0;
            end
        end
    end

endmodule

// ==== dv/fetch_tb.sv ====
/*
 * Fetch block testbench
 * Runs a random forward-flowing program with traps, stops, restarts
 * and a fault halt, and checks fetches, retires and host registers
 * against a reference model of the PC rules.
 */
`timescale 1ns/10ps
`include "pc_params.svh"

module fetch_tb;

    localparam int mem_words      = 64;
    localparam int trap_word      = 56;  // Handler runs straight through 56 to 61
    localparam int back_word      = 62;  // Branches back to word 1
    localparam int main_retires   = 200;
    localparam int resume_retires = 50;
    // At most about 12 cycles per instruction, plus host accesses and idle checks
    localparam int cycle_limit    = (main_retires + resume_retires) * 12 + 1000;

    logic              clk;
    logic              reset;
    logic              imem_req;
    pc_pkg::addr_t     imem_addr;
    logic              imem_ack;
    pc_pkg::instr_t    imem_rdata;
    logic              cond;
    logic              cfg_req;
    logic              cfg_we;
    pc_pkg::cfg_addr_t cfg_addr;
    pc_pkg::cfg_data_t cfg_wdata;
    logic              cfg_ack;
    pc_pkg::cfg_data_t cfg_rdata;
    logic              halted;
    logic              retire;
    pc_pkg::addr_t     retire_pc;

    pc_pkg::instr_t       prog [0:mem_words-1]; // Same words as the memory model
    pc_pkg::addr_t        exp_addr;             // Next fetch address
    pc_pkg::addr_t        model_trap_vec;
    logic                 model_trap_en;
    pc_pkg::fault_count_t model_faults;
    pc_pkg::addr_t        retire_q [$];         // Fetched and not yet retired
    int                   retire_count;
    int                   cycle_count = 0;
    logic                 req_seen;
    logic                 flt;

    fetch_top UUT (
        .clk(clk), .reset(reset), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_rdata(imem_rdata), .cond(cond),
        .cfg_req(cfg_req), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata), .halted(halted), .retire(retire),
        .retire_pc(retire_pc)
    );

    imem_model #(.words(mem_words)) mem_model (
        .clk(clk), .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
        .imem_rdata(imem_rdata), .cond(cond)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_addr(input pc_pkg::addr_t got, input pc_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run({what, " does not match the model"});
        end
    endtask

    task automatic check_data(input pc_pkg::cfg_data_t got, input pc_pkg::cfg_data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run({what, " does not match the model"});
        end
    endtask

    task automatic check_count(input pc_pkg::fault_count_t got,
                               input pc_pkg::fault_count_t exp, input string what);
        if (got !== exp) begin
            $display("Error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run({what, " does not match the model"});
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error: time %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run({what, " has the wrong level"});
        end
    endtask

    task automatic host_write(input pc_pkg::cfg_addr_t addr, input pc_pkg::cfg_data_t data);
        @(posedge clk);
        #1;
        cfg_req   = 1'b1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        do begin
            @(posedge clk);
            #1;
        end while (!cfg_ack);
        cfg_req = 1'b0;
        cfg_we  = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (cfg_ack);
    endtask

    task automatic host_read(input pc_pkg::cfg_addr_t addr, output pc_pkg::cfg_data_t data);
        @(posedge clk);
        #1;
        cfg_req  = 1'b1;
        cfg_we   = 1'b0;
        cfg_addr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!cfg_ack);
        data    = cfg_rdata; // Valid while ack is high
        cfg_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (cfg_ack);
    endtask

    task automatic wait_retires(input int n);
        int target;
        target = retire_count + n;
        while (retire_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_halted();
        @(posedge clk);
        #1;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        if (retire_q.size() != 0) begin
            abort_run("Sequencer went idle with a fetched instruction not retired");
        end
    endtask

    task automatic expect_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            if (imem_req || !halted) begin
                abort_run("Sequencer fetched again after it should have stopped");
            end
        end
    endtask

    // Status register with pc in 31:2 and halted in bit 0
    function automatic pc_pkg::cfg_data_t status_word(input pc_pkg::addr_t pc, input logic h);
        return {pc[31:2], 1'b0, h};
    endfunction

    // Next fetch address after one instruction including the trap redirect
    function automatic pc_pkg::addr_t next_fetch(
        input  pc_pkg::addr_t  pc,
        input  pc_pkg::instr_t word,
        input  logic           taken,
        input  logic           trap_en,
        input  pc_pkg::addr_t  vector,
        output logic           fault_out
    );
        pc_pkg::addr_t soffset;
        pc_pkg::addr_t target;
        logic [1:0]    kind;
        kind      = word[31:30];
        soffset   = {{2{word[29]}}, word[29:0]};
        fault_out = 1'b0;
        if (kind == 2'd3) begin
            kind = taken ? 2'd2 : 2'd0; // Conditional acts as branch or sequential
        end
        case (kind)
            2'd0: target = pc + `PC_STEP;
            2'd1: begin
                target    = {2'b00, word[29:2], 2'b00};
                fault_out = word[1];
            end
            default: begin
                target    = pc + {soffset[31:2], 2'b00};
                fault_out = soffset[1] | soffset[0];
            end
        endcase
        if (fault_out && trap_en) begin
            target = vector;
        end
        return target;
    endfunction

    // Forward-only control flow, so every path reaches the handler and loops back
    task automatic build_program();
        int i;
        int span;
        int tgt;
        int pick;
        for (i = 0; i < mem_words; i++) begin
            prog[i] = {2'b00, 30'(i)};
        end
        prog[0] = {2'b10, 30'd9}; // Misaligned branch that traps on the first fetch
        for (i = 1; i < trap_word - 1; i++) begin
            span = (trap_word - i < 8) ? trap_word - i : 8;
            tgt  = i + 1 + int'($urandom % span);
            pick = int'($urandom % 16);
            if (pick < 2) begin
                prog[i] = {2'b01, 30'(tgt * 4)};
            end else if (pick < 4) begin
                prog[i] = {2'b10, 30'((tgt - i) * 4)};
            end else if (pick < 8) begin
                prog[i] = {2'b11, 30'((tgt - i) * 4)};
            end else if (pick == 8) begin
                prog[i] = {2'b10, 30'((tgt - i) * 4 + 2)}; // Offset bit 1 set
            end else if (pick == 9) begin
                prog[i] = {2'b01, 30'(tgt * 4 + 2)};       // Jump target bit 1 set
            end
        end
        prog[back_word]   = {2'b10, 30'((1 - back_word) * 4)}; // Negative offset
        prog[mem_words-1] = {2'b01, 30'd0};
        for (i = 0; i < mem_words; i++) begin
            mem_model.mem[i] = prog[i];
        end
    endtask

    // Fetch and retire monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (imem_req && !req_seen) begin
                check_addr(imem_addr, exp_addr, "Fetch address");
            end
            if (imem_req && imem_ack) begin // Sequencer captures on the next edge
                retire_q.push_back(exp_addr);
                exp_addr = next_fetch(exp_addr, prog[exp_addr[7:2]], cond, model_trap_en,
                                      model_trap_vec, flt);
                if (flt) begin
                    model_faults = model_faults + 1'b1;
                end
            end
            if (retire) begin
                if (retire_q.size() == 0) begin
                    abort_run("Retire pulse with no fetched instruction outstanding");
                end
                check_addr(retire_pc, retire_q.pop_front(), "Retire PC");
                retire_count++;
            end
        end
        req_seen = imem_req;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run("Run did not finish within the cycle limit");
        end
    end

    initial begin
        pc_pkg::cfg_data_t rd;
        int                idx;
        void'($urandom(86));
        clk            = 1'b0;
        reset          = 1'b1;
        cfg_req        = 1'b0;
        cfg_we         = 1'b0;
        cfg_addr       = '0;
        cfg_wdata      = '0;
        exp_addr       = '0;
        model_trap_vec = '0;
        model_trap_en  = 1'b0;
        model_faults   = '0;
        retire_count   = 0;
        req_seen       = 1'b0;
        repeat (5) @(posedge clk);
        build_program();
        #1;
        reset = 1'b0;

        check_flag(imem_req, 1'b0, "imem_req after reset");
        check_flag(cfg_ack, 1'b0, "cfg_ack after reset");
        check_flag(halted, 1'b1, "halted after reset");
        host_read(`CFG_REG_STATUS, rd);
        check_data(rd, status_word('0, 1'b1), "Status after reset");
        host_read(`CFG_REG_CTRL, rd);
        check_data(rd, '0, "Control after reset");
        host_read(`CFG_REG_FAULTS, rd);
        check_count(pc_pkg::fault_count_t'(rd), '0, "Fault count after reset");

        // Random program with traps enabled
        host_write(`CFG_REG_TRAP, pc_pkg::cfg_data_t'(trap_word * 4));
        model_trap_vec = pc_pkg::addr_t'(trap_word * 4);
        model_trap_en  = 1'b1;
        host_write(`CFG_REG_CTRL, 32'd3);
        wait_retires(main_retires);
        host_write(`CFG_REG_CTRL, 32'd2); // Stop with traps left on
        wait_halted();
        expect_idle(20);
        host_read(`CFG_REG_FAULTS, rd);
        check_count(pc_pkg::fault_count_t'(rd), model_faults, "Fault count");
        host_read(`CFG_REG_STATUS, rd);
        check_data(rd, status_word(exp_addr, 1'b1), "Status after stop");

        // Clear the counter and resume from the stopped PC
        host_write(`CFG_REG_FAULTS, 32'hFFFF_FFFF);
        model_faults = '0;
        host_read(`CFG_REG_FAULTS, rd);
        check_count(pc_pkg::fault_count_t'(rd), '0, "Fault count after clear");
        host_write(`CFG_REG_CTRL, 32'd3);
        wait_retires(resume_retires);
        host_write(`CFG_REG_CTRL, 32'd2);
        wait_halted();

        // Traps off and a jump with bit 1 set planted at the next fetch
        idx                = int'(exp_addr[7:2]);
        prog[idx]          = {2'b01, 30'd82}; // Target 0x50 with bit 1 set
        mem_model.mem[idx] = prog[idx];
        model_trap_en      = 1'b0;
        host_write(`CFG_REG_CTRL, 32'd1);
        wait_retires(1);
        wait_halted();
        expect_idle(20);
        host_read(`CFG_REG_CTRL, rd);
        check_data(rd, '0, "Control after fault halt");
        host_read(`CFG_REG_STATUS, rd);
        check_data(rd, status_word(exp_addr, 1'b1), "Status after fault halt");
        host_read(`CFG_REG_FAULTS, rd);
        check_count(pc_pkg::fault_count_t'(rd), model_faults, "Fault count after halt");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/pc_pkg.sv
hw/program_counter.sv
hw/flow_decoder.sv
hw/fetch_sequencer.sv
hw/fetch_config.sv
hw/fetch_top.sv
dv/imem_model.sv
dv/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch block testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = fetch_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# A $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
